/* bench/m68kDramControllerStimulus.txt */
# op address data strobes(UDS_L LDS_L), W write, R read, I idle cycles given by data
# P and Q are a write and a read started once a refresh has begun
W 00812345 BEEF 00
R 00812345 A5C3 00
W 01FFFC04 1357 01
R 01FFFC04 2468 10
I 00000000 0096 11
W 00000000 0001 00
P 00C00ABC 55AA 00
Q 00C00ABC 0F0F 00
R 017FFFFF FFFF 00
W 00455556 CAFE 00

/* m68kDramController.f */
hdl/sdramPkg.sv
hdl/cpuRequestCapture.sv
hdl/intervalTimers.sv
hdl/dramSequencer.sv
hdl/sdramPinDriver.sv
hdl/m68kDramController.sv
bench/m68kDramController_chk.sv
bench/m68kDramControllerTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# Build and run the controller testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module m68kDramControllerTb \
	-f m68kDramController.f \
	-Mdir obj_dir -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log || ! grep -q "STATUS: PASS" sim.log; then
	exit 1
fi
exit 0

/* bench/m68kDramControllerTb.sv */
`timescale 1ns/100ps
`default_nettype none

module m68kDramControllerTb;
	import sdramPkg::*;

	localparam int TestRefresh = 60;                        // shortened so idle gaps see several refreshes
	localparam int InitBound = 120;                         // cycles the whole power up sequence may take

	// mode word with single writes on A9, CAS latency 2 on A6 to A4 and burst length 1 on A2 to A0
	localparam logic [RowWidth-1:0] ExpModeWord = {3'b000, 1'b1, 2'b00, 3'b010, 1'b0, 3'b000};

	logic                 Clock;
	logic                 Reset_L;
	logic [31:0]          Address;
	logic [DataWidth-1:0] DataIn;
	logic                 UDS_L;
	logic                 LDS_L;
	logic                 DramSelect_L;
	logic                 WE_L;
	logic                 AS_L;
	logic [DataWidth-1:0] DataOut;
	logic                 SDram_CKE_H;
	logic                 SDram_CS_L;
	logic                 SDram_RAS_L;
	logic                 SDram_CAS_L;
	logic                 SDram_WE_L;
	logic [RowWidth-1:0]  SDram_Addr;
	logic [BankWidth-1:0] SDram_BA;
	wire  [DataWidth-1:0] SDram_DQ;
	logic                 Dtack_L;
	logic                 ResetOut_L;

	logic                 dqDriveEn;                        // the bench plays the SDRAM during reads
	logic [DataWidth-1:0] dqDrive;
	assign SDram_DQ = dqDriveEn ? dqDrive : 'z;

	string                opList[$];                        // one entry per stimulus line
	logic [31:0]          addrList[$];
	logic [DataWidth-1:0] dataList[$];
	logic [1:0]           strobeList[$];
	logic                 loaded;

	logic [BankWidth-1:0] expBank;                          // fields the monitor expects on the pins
	logic [RowWidth-1:0]  expRow;
	logic [ColWidth-1:0]  expCol;
	logic [DataWidth-1:0] expData;
	logic                 sawActivate;
	logic                 sawAccessCmd;
	int                   cycle;
	int                   refPreCount;                      // refresh precharges seen after init
	int                   lastRefresh;
	logic                 busySinceRefresh;                 // a CPU access may have delayed the refresh
	sdramCmd_e            prevCmd;
	sdramCmd_e            prevCmd2;
	int                   initRefreshes;
	logic                 sawNop;
	logic                 sawInitPre;
	logic                 sawMode;
	logic                 initDone;

	m68kDramController #(.RefreshInterval(TestRefresh)) u_dut (.*);

	initial begin
		Clock = 1'b0;
		forever #5 Clock = ~Clock;
	end

	task automatic failNow(input string msg);
		$display("FAILURE at time %0t: %s", $time, msg);
		$display("STATUS: FAIL");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic checkCommand(input string name, input sdramCmd_e got, input sdramCmd_e exp);
		if (got !== exp) begin
			$display("ERR time=%0t %s got=%s expected=%s", $time, name, got.name(), exp.name());
			$display("STATUS: FAIL");
			$fatal(1, "command mismatch");
		end
	endtask

	task automatic checkWord(input string name, input logic [DataWidth-1:0] got,
		input logic [DataWidth-1:0] exp);
		if (got !== exp) begin
			$display("ERR time=%0t %s got=%h expected=%h", $time, name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "data mismatch");
		end
	endtask

	task automatic checkAddress(input string name, input logic [RowWidth-1:0] got,
		input logic [RowWidth-1:0] exp);
		if (got !== exp) begin
			$display("ERR time=%0t %s got=%h expected=%h", $time, name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "address mismatch");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// pin monitor, sampled mid cycle where the registered pins are stable
	//////////////////////////////////////////////////////////////////////

	always @(negedge Clock) begin
		sdramCmd_e cmd;
		cmd = sdramCmd_e'({SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L});
		if (Reset_L) begin
			cycle++;
			if (!initDone) begin
				if (!sawNop) begin
					if (cmd == CmdNop) sawNop = 1'b1;   // CKE has come up
					else checkCommand("SDram_Cmd", cmd, CmdPowerUp);
				end else if (cmd == CmdPrecharge) begin
					if (!SDram_Addr[AutoPrechargeBit]) failNow("init precharge without A10 set");
					sawInitPre = 1'b1;
				end else if (cmd == CmdAutoRefresh && sawInitPre) begin
					initRefreshes++;
				end else if (cmd == CmdModeSet) begin
					if (initRefreshes < 2)
						failNow("mode register loaded before the initial refreshes");
					checkAddress("SDram_Addr", SDram_Addr, ExpModeWord);
					sawMode = 1'b1;
				end
				if (ResetOut_L) begin                       // end of initialisation
					if (!sawInitPre || initRefreshes < 2 || !sawMode)
						failNow("ResetOut_L rose before the init sequence was complete");
					initDone = 1'b1;
					lastRefresh = cycle;
					busySinceRefresh = 1'b1;                // first interval is not measured
				end
			end else begin
				case (cmd)
					CmdPrecharge: begin
						if (!SDram_Addr[AutoPrechargeBit]) failNow("refresh precharge without A10");
						refPreCount++;
					end
					CmdAutoRefresh: begin
						checkCommand("SDram_Cmd before refresh", prevCmd, CmdNop);
						checkCommand("SDram_Cmd two before refresh", prevCmd2, CmdPrecharge);
						if (!busySinceRefresh && cycle - lastRefresh > TestRefresh + 10)
							failNow($sformatf("refreshes %0d cycles apart", cycle - lastRefresh));
						lastRefresh = cycle;
						busySinceRefresh = !AS_L;
					end
					CmdActivate: begin
						checkAddress("SDram_Addr row", SDram_Addr, expRow);
						checkAddress("SDram_BA", RowWidth'(SDram_BA), RowWidth'(expBank));
						sawActivate = 1'b1;
					end
					CmdWrite: begin
						checkAddress("SDram_Addr column", SDram_Addr, {2'b00, 1'b1, expCol});
						checkAddress("SDram_BA", RowWidth'(SDram_BA), RowWidth'(expBank));
						checkWord("SDram_DQ", SDram_DQ, expData);
						sawAccessCmd = 1'b1;
					end
					CmdRead: begin
						checkAddress("SDram_Addr column", SDram_Addr, {2'b00, 1'b1, expCol});
						checkAddress("SDram_BA", RowWidth'(SDram_BA), RowWidth'(expBank));
						dqDrive = expData;                  // SDRAM word shows up after CAS latency
						dqDriveEn = 1'b1;
						sawAccessCmd = 1'b1;
					end
					default: ;
				endcase
				if (!AS_L) busySinceRefresh = 1'b1;
			end
			prevCmd2 = prevCmd;
			prevCmd = cmd;
		end
	end

	// one 68000 bus cycle, P and Q first wait for a refresh to begin
	task automatic runAccess(input string op, input logic [31:0] addr,
		input logic [DataWidth-1:0] data, input logic [1:0] strobes);
		int   startCount;
		int   waitCycles;
		logic isWrite;
		startCount = refPreCount;
		isWrite = (op == "W" || op == "P");
		if (op == "P" || op == "Q") wait (refPreCount != startCount);
		@(negedge Clock);
		expBank = addr[24:23];
		expRow = addr[22:10];
		expCol = addr[9:0];
		expData = data;
		sawActivate = 1'b0;
		sawAccessCmd = 1'b0;
		Address = addr;
		DataIn = isWrite ? data : '0;
		WE_L = !isWrite;
		DramSelect_L = 1'b0;
		AS_L = 1'b0;
		{UDS_L, LDS_L} = strobes;
		waitCycles = 0;
		while (Dtack_L) begin
			@(negedge Clock);
			waitCycles++;
			if (waitCycles > 40) failNow("Dtack_L never went low");
		end
		if (!isWrite) checkWord("DataOut", DataOut, data);
		repeat (2) begin                                    // CPU holds AS_L low a little longer
			@(negedge Clock);
			if (Dtack_L) failNow("Dtack_L rose while AS_L was still low");
		end
		AS_L = 1'b1;                                        // end of the bus cycle
		DramSelect_L = 1'b1;
		{UDS_L, LDS_L} = 2'b11;
		WE_L = 1'b1;
		dqDriveEn = 1'b0;
		waitCycles = 0;
		while (!Dtack_L) begin
			@(negedge Clock);
			waitCycles++;
			if (waitCycles > 4) failNow("Dtack_L stayed low after AS_L was released");
		end
		if (!sawActivate || !sawAccessCmd) failNow("access finished without its SDRAM commands");
	endtask

	initial begin
		int                   fd;
		int                   gap;
		string                line;
		string                op;
		logic [31:0]          a;
		logic [DataWidth-1:0] d;
		logic [1:0]           s;
		void'($urandom(36));
		{Address, DataIn, WE_L} = '0;
		{UDS_L, LDS_L, DramSelect_L, AS_L} = 4'hf;
		WE_L = 1'b1;
		Reset_L = 1'b0;
		{dqDriveEn, dqDrive, loaded, sawNop, sawInitPre, sawMode, initDone} = '0;
		{cycle, refPreCount, lastRefresh, initRefreshes} = '0;
		{sawActivate, sawAccessCmd, busySinceRefresh} = '0;
		{expBank, expRow, expCol, expData} = '0;
		prevCmd = CmdPowerUp;
		prevCmd2 = CmdPowerUp;
		fd = $fopen("bench/m68kDramControllerStimulus.txt", "r");
		if (fd == 0) failNow("stimulus file could not be opened");
		while (!$feof(fd)) begin
			if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#") begin
				if ($sscanf(line, "%s %h %h %b", op, a, d, s) == 4) begin
					opList.push_back(op);
					addrList.push_back(a);
					dataList.push_back(d);
					strobeList.push_back(s);
				end
			end
		end
		$fclose(fd);
		loaded = 1'b1;
		repeat (3) @(posedge Clock);
		@(negedge Clock);
		Reset_L = 1'b1;
		wait (initDone);
		foreach (opList[i]) begin
			if (opList[i] == "I") begin
				repeat (dataList[i]) @(negedge Clock);  // long idle gap for refresh spacing
			end else begin
				gap = $urandom % 6;
				repeat (gap) @(negedge Clock);
				runAccess(opList[i], addrList[i], dataList[i], strobeList[i]);
			end
		end
		repeat (5) @(negedge Clock);
		$display("STATUS: PASS");
		$finish;
	end

	initial begin
		longint limitNs;
		wait (loaded);
		limitNs = 2 * (longint'(opList.size()) * (TestRefresh + 20) + InitBound) * 10;
		#(limitNs);
		$display("run did not finish within %0d ns", limitNs);
		$display("STATUS: FAIL");
		$fatal(1, "watchdog timeout");
	end

endmodule

`default_nettype wire

/* bench/m68kDramController_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module m68kDramController_chk (
	input wire logic Clock,
	input wire logic Reset_L,
	input wire logic SDram_CKE_H,
	input wire logic SDram_CS_L,
	input wire logic SDram_RAS_L,
	input wire logic SDram_CAS_L,
	input wire logic SDram_WE_L,
	input wire logic dqEnable,                              // the controller's own DQ enable
	input wire logic Dtack_L,
	input wire logic ResetOut_L
);
	import sdramPkg::*;

	logic [4:0] cmd;
	assign cmd = {SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L};

	accessAfterInit: assert property (@(posedge Clock) disable iff (!Reset_L)
		(cmd == CmdRead || cmd == CmdWrite) |-> ResetOut_L) else $error("access during init");
	dqOnlyForWrite: assert property (@(posedge Clock) disable iff (!Reset_L)
		dqEnable |-> (cmd == CmdWrite || $past(cmd) == CmdWrite)) else $error("stray DQ drive");
	dtackAfterInit: assert property (@(posedge Clock) disable iff (!Reset_L)
		!Dtack_L |-> ResetOut_L) else $error("Dtack_L low during init");
	dtackIdleAtReset: assert property (@(posedge Clock)
		$rose(Reset_L) |-> Dtack_L) else $error("Dtack_L low after reset");

endmodule

bind m68kDramController m68kDramController_chk u_chk (
	.Clock, .Reset_L, .SDram_CKE_H, .SDram_CS_L, .SDram_RAS_L, .SDram_CAS_L, .SDram_WE_L,
	.dqEnable(u_pins.dqEnable), .Dtack_L, .ResetOut_L
);

`default_nettype wire

/* hdl/m68kDramController.sv */
`timescale 1ns/100ps
`default_nettype none

module m68kDramController #(
	parameter int PowerUpCycles = 7,
	parameter int InitRefreshCycles = 39,
	parameter int RefreshInterval = 375
) (
	input  wire logic                           Clock,
	input  wire logic                           Reset_L,
	input  wire logic [31:0]                    Address,
	input  wire logic [sdramPkg::DataWidth-1:0] DataIn,
	input  wire logic                           UDS_L,
	input  wire logic                           LDS_L,
	input  wire logic                           DramSelect_L,
	input  wire logic                           WE_L,
	input  wire logic                           AS_L,
	output      logic [sdramPkg::DataWidth-1:0] DataOut,
	output      logic                           SDram_CKE_H,
	output      logic                           SDram_CS_L,
	output      logic                           SDram_RAS_L,
	output      logic                           SDram_CAS_L,
	output      logic                           SDram_WE_L,
	output      logic [sdramPkg::RowWidth-1:0]  SDram_Addr,
	output      logic [sdramPkg::BankWidth-1:0] SDram_BA,
	inout  wire logic [sdramPkg::DataWidth-1:0] SDram_DQ,
	output      logic                           Dtack_L,
	output      logic                           ResetOut_L
);
	import sdramPkg::*;

	cpuRequest_t request;                                   // captured CPU transaction
	sdramDrive_t drive;                                     // sequencer decision for the next edge
	logic        accessStart;
	logic        capture;
	logic        dataCapture;
	logic        loadPowerUp;
	logic        loadInitRefresh;
	logic        loadRefresh;
	logic        timerDone;
	logic        refreshDue;

	cpuRequestCapture u_capture (
		.Clock, .Reset_L, .Address, .DataIn, .DramSelect_L, .AS_L, .WE_L,
		.capture, .dataCapture, .request, .accessStart
	);

	intervalTimers #(
		.PowerUpCycles(PowerUpCycles),
		.InitRefreshCycles(InitRefreshCycles),
		.RefreshInterval(RefreshInterval)
	) u_timers (
		.Clock, .Reset_L, .loadPowerUp, .loadInitRefresh, .loadRefresh, .timerDone, .refreshDue
	);

	dramSequencer u_sequencer (
		.Clock, .Reset_L, .request, .accessStart, .UDS_L, .LDS_L, .AS_L, .timerDone, .refreshDue,
		.capture, .dataCapture, .loadPowerUp, .loadInitRefresh, .loadRefresh, .drive
	);

	sdramPinDriver u_pins (
		.Clock, .Reset_L, .drive, .writeData(request.writeData), .SDram_DQ,
		.SDram_CKE_H, .SDram_CS_L, .SDram_RAS_L, .SDram_CAS_L, .SDram_WE_L,
		.SDram_Addr, .SDram_BA, .Dtack_L, .ResetOut_L, .DataOut
	);

endmodule

`default_nettype wire

/* hdl/sdramPinDriver.sv */
`timescale 1ns/100ps
`default_nettype none

module sdramPinDriver (
	input  wire logic                           Clock,
	input  wire logic                           Reset_L,
	input  wire sdramPkg::sdramDrive_t          drive,
	input  wire logic [sdramPkg::DataWidth-1:0] writeData,
	inout  wire logic [sdramPkg::DataWidth-1:0] SDram_DQ,
	output      logic                           SDram_CKE_H,
	output      logic                           SDram_CS_L,
	output      logic                           SDram_RAS_L,
	output      logic                           SDram_CAS_L,
	output      logic                           SDram_WE_L,
	output      logic [sdramPkg::RowWidth-1:0]  SDram_Addr,
	output      logic [sdramPkg::BankWidth-1:0] SDram_BA,
	output      logic                           Dtack_L,
	output      logic                           ResetOut_L,
	output      logic [sdramPkg::DataWidth-1:0] DataOut
);
	import sdramPkg::*;

	logic                 dqEnable;                         // FPGA drives DQ when set
	logic [DataWidth-1:0] dqOut;                            // registered write word
	logic                 readLatch;                        // registered latchRead for the falling edge

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			{SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L} <= CmdPowerUp;
			dqEnable <= 1'b0;                               // DQ released
			readLatch <= 1'b0;
			Dtack_L <= 1'b1;
			ResetOut_L <= 1'b0;                             // CPU held until init is over
		end else begin
			{SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L} <= drive.cmd;
			dqEnable <= drive.driveData;
			readLatch <= drive.latchRead;
			Dtack_L <= !drive.dtack;                        // pins are active low
			ResetOut_L <= drive.cpuRun;
		end
	end

	always_ff @(posedge Clock) begin
		SDram_Addr <= drive.addr;
		SDram_BA <= drive.bank;
		dqOut <= writeData;
	end

	assign SDram_DQ = dqEnable ? dqOut : 'z;                // SDRAM owns the lines otherwise

	// read data is sampled mid cycle, well inside the SDRAM output valid window
	always_ff @(negedge Clock) begin
		if (readLatch) begin
			DataOut <= SDram_DQ;                            // held for the CPU until the next read
		end
	end

endmodule

`default_nettype wire

/* hdl/dramSequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module dramSequencer (
	input  wire logic                  Clock,
	input  wire logic                  Reset_L,
	input  wire sdramPkg::cpuRequest_t request,
	input  wire logic                  accessStart,
	input  wire logic                  UDS_L,
	input  wire logic                  LDS_L,
	input  wire logic                  AS_L,
	input  wire logic                  timerDone,
	input  wire logic                  refreshDue,
	output      logic                  capture,
	output      logic                  dataCapture,
	output      logic                  loadPowerUp,
	output      logic                  loadInitRefresh,
	output      logic                  loadRefresh,
	output      sdramPkg::sdramDrive_t drive
);
	import sdramPkg::*;

	seqState_e state;                                       // current controller state
	seqState_e nextState;

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state <= StInit;                                // every reset restarts the power up sequence
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;                                  // stay unless a case moves on
		capture = 1'b0;
		dataCapture = 1'b0;
		loadPowerUp = 1'b0;
		loadInitRefresh = 1'b0;
		loadRefresh = 1'b0;
		drive.cmd = CmdNop;
		drive.addr = '0;
		drive.bank = '0;
		drive.driveData = 1'b0;
		drive.latchRead = 1'b0;
		drive.dtack = 1'b0;
		drive.cpuRun = !(state inside {[StInit:StModeNop3]}); // CPU held in reset until init ends

		case (state)
			//////////////////////////////////////////////////////////////////////
			// power up and initialisation
			//////////////////////////////////////////////////////////////////////
			StInit: begin
				drive.cmd = CmdPowerUp;
				loadPowerUp = 1'b1;
				nextState = StPowerWait;
			end
			StPowerWait: begin
				drive.cmd = CmdPowerUp;                     // CKE stays low for the whole wait
				if (timerDone) begin
					nextState = StInitNop;
				end
			end
			StInitNop: nextState = StInitPrecharge;         // first command with CKE high
			StInitPrecharge: begin
				drive.cmd = CmdPrecharge;
				drive.addr[AutoPrechargeBit] = 1'b1;        // all banks
				nextState = StInitNop2;
			end
			StInitNop2: begin
				loadInitRefresh = 1'b1;                     // span of the refresh loop below
				nextState = StInitRefresh;
			end
			StInitRefresh: begin
				drive.cmd = CmdAutoRefresh;
				nextState = StInitNop3;
			end
			StInitNop3: nextState = StInitNop4;
			StInitNop4: nextState = StInitNop5;
			StInitNop5: begin
				nextState = timerDone ? StModeSet : StInitRefresh; // keep refreshing until the span ends
			end
			StModeSet: begin
				drive.cmd = CmdModeSet;
				drive.addr = ModeRegisterValue;             // bank stays zero for the base mode register
				nextState = StModeNop1;
			end
			StModeNop1: nextState = StModeNop2;
			StModeNop2: nextState = StModeNop3;
			StModeNop3: begin
				loadRefresh = 1'b1;                         // first refresh interval starts here
				nextState = StIdle;
			end

			//////////////////////////////////////////////////////////////////////
			// idle and CPU accesses
			//////////////////////////////////////////////////////////////////////
			StIdle: begin
				if (refreshDue) begin
					nextState = StRefPrecharge;             // refresh wins over a waiting CPU
				end else if (accessStart) begin
					capture = 1'b1;
					drive.cmd = CmdActivate;
					drive.addr = request.row;
					drive.bank = request.bank;
					nextState = request.isWrite ? StActivateWait : StReadCmd;
				end
			end
			StActivateWait: begin
				if (!UDS_L || !LDS_L) begin                 // write data is valid on the bus now
					dataCapture = 1'b1;
					drive.cmd = CmdWrite;
					drive.addr = RowWidth'(request.column);
					drive.addr[AutoPrechargeBit] = 1'b1;
					drive.bank = request.bank;
					drive.driveData = 1'b1;
					drive.dtack = 1'b1;
					nextState = StWrite;
				end
			end
			StWrite: begin
				drive.driveData = 1'b1;                     // data held one more cycle after the write
				drive.dtack = 1'b1;
				nextState = StCycleEnd;
			end
			StReadCmd: begin
				drive.cmd = CmdRead;
				drive.addr = RowWidth'(request.column);
				drive.addr[AutoPrechargeBit] = 1'b1;        // precharge once the word is out
				drive.bank = request.bank;
				nextState = StReadWait;
			end
			StReadWait: nextState = StReadLatch;            // first cycle of CAS latency
			StReadLatch: begin
				drive.latchRead = 1'b1;                     // lands on the falling edge after CAS latency
				nextState = StCycleEnd;
			end
			StCycleEnd: begin
				drive.dtack = 1'b1;
				if (AS_L) begin                             // CPU has finished its bus cycle
					nextState = StIdle;
				end
			end

			//////////////////////////////////////////////////////////////////////
			// periodic refresh
			//////////////////////////////////////////////////////////////////////
			StRefPrecharge: begin
				drive.cmd = CmdPrecharge;
				drive.addr[AutoPrechargeBit] = 1'b1;
				nextState = StRefNop;
			end
			StRefNop: nextState = StRefCmd;
			StRefCmd: begin
				drive.cmd = CmdAutoRefresh;
				nextState = StRefNop1;
			end
			StRefNop1: nextState = StRefNop2;
			StRefNop2: nextState = StRefNop3;
			StRefNop3: begin
				loadRefresh = 1'b1;
				nextState = StIdle;
			end
			default: nextState = StInit;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/intervalTimers.sv */
`timescale 1ns/100ps
`default_nettype none

module intervalTimers #(
	parameter int PowerUpCycles = 7,
	parameter int InitRefreshCycles = 39,
	parameter int RefreshInterval = 375
) (
	input  wire logic Clock,
	input  wire logic Reset_L,
	input  wire logic loadPowerUp,                          // start the power up wait
	input  wire logic loadInitRefresh,                      // start the initial refresh loop span
	input  wire logic loadRefresh,                          // restart the refresh interval
	output      logic timerDone,
	output      logic refreshDue
);

	// general timer only needs to hold the larger of its two load values
	localparam int GenMax = (PowerUpCycles > InitRefreshCycles) ? PowerUpCycles : InitRefreshCycles;
	localparam int GenWidth = $clog2(GenMax + 1);
	localparam int RefWidth = $clog2(RefreshInterval + 1);

	logic [GenWidth-1:0] genCount;                          // counts down and parks at zero
	logic [RefWidth-1:0] refCount;                          // cycles left until the next refresh

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			genCount <= '0;
		end else if (loadPowerUp) begin
			genCount <= GenWidth'(PowerUpCycles);
		end else if (loadInitRefresh) begin
			genCount <= GenWidth'(InitRefreshCycles);
		end else if (genCount != '0) begin
			genCount <= genCount - 1'b1;                    // stops once it reaches zero
		end
	end

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			refCount <= '0;                                 // due at once, but ignored until idle
		end else if (loadRefresh) begin
			refCount <= RefWidth'(RefreshInterval);
		end else if (refCount != '0) begin
			refCount <= refCount - 1'b1;
		end
	end

	assign timerDone = (genCount == '0);
	assign refreshDue = (refCount == '0);                   // stays set until the next reload

endmodule

`default_nettype wire

/* hdl/cpuRequestCapture.sv */
`timescale 1ns/100ps
`default_nettype none

module cpuRequestCapture (
	input  wire logic                          Clock,
	input  wire logic                          Reset_L,
	input  wire logic [31:0]                   Address,       // full 68000 address bus
	input  wire logic [sdramPkg::DataWidth-1:0] DataIn,
	input  wire logic                          DramSelect_L,
	input  wire logic                          AS_L,
	input  wire logic                          WE_L,          // low for a CPU write
	input  wire logic                          capture,       // one cycle pulse when a request is taken
	input  wire logic                          dataCapture,   // one cycle pulse when a strobe arrives
	output      sdramPkg::cpuRequest_t         request,
	output      logic                          accessStart
);
	import sdramPkg::*;

	cpuRequest_t liveRequest;                               // fields split straight off the bus
	cpuRequest_t heldRequest;                               // fields kept for the whole transaction

	always_comb begin
		liveRequest.bank = Address[24:23];                  // bank select bits
		liveRequest.row = Address[22:10];                   // 13 bit row
		liveRequest.column = Address[9:0];                  // 10 bit column
		liveRequest.isWrite = !WE_L;
		liveRequest.writeData = DataIn;
	end

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			heldRequest <= '0;
		end else if (capture) begin
			heldRequest <= liveRequest;                     // whole request at the start of a cycle
		end else if (dataCapture) begin
			heldRequest.writeData <= DataIn;                // data is only valid once a strobe is low
		end
	end

	// the capture cycle itself already needs the fields, so they pass straight through then
	always_comb begin
		request = heldRequest;
		if (capture) begin
			request = liveRequest;
		end else if (dataCapture) begin
			request.writeData = DataIn;                     // same bypass for the write word
		end
	end

	assign accessStart = !DramSelect_L && !AS_L;            // CPU has put a DRAM address on the bus

endmodule

`default_nettype wire

/* hdl/sdramPkg.sv */
`default_nettype none

package sdramPkg;

	//////////////////////////////////////////////////////////////////////
	// widths of the 68000 side and the SDRAM side
	//////////////////////////////////////////////////////////////////////

	localparam int DataWidth = 16;                          // one 16 bit word per access
	localparam int RowWidth = 13;                           // 8192 rows, also the SDRAM address bus
	localparam int ColWidth = 10;                           // 1024 columns per row
	localparam int BankWidth = 2;                           // four internal banks
	localparam int AutoPrechargeBit = 10;                   // A10 selects auto or all-bank precharge

	localparam logic [RowWidth-1:0] ModeRegisterValue = 13'h220; // CAS latency 2 with burst length 1

	// command bits are CKE, CS, RAS, CAS and WE from msb to lsb
	typedef enum logic [4:0] {
		CmdPowerUp     = 5'b00000,                          // CKE and CS held low while power settles
		CmdNop         = 5'b10111,
		CmdRead        = 5'b10101,                          // auto precharge when A10 is high
		CmdWrite       = 5'b10100,                          // auto precharge when A10 is high
		CmdAutoRefresh = 5'b10001,
		CmdActivate    = 5'b10011,                          // opens the row given on the address bus
		CmdPrecharge   = 5'b10010,                          // all banks when A10 is high
		CmdModeSet     = 5'b10000
	} sdramCmd_e;

	// the initialisation states come first so that a range test finds them
	typedef enum logic [4:0] {
		StInit, StPowerWait,
		StInitNop, StInitPrecharge,
		StInitNop2, StInitRefresh, StInitNop3, StInitNop4, StInitNop5,
		StModeSet, StModeNop1, StModeNop2, StModeNop3,
		StIdle, StActivateWait, StWrite,
		StReadCmd, StReadWait, StReadLatch,
		StCycleEnd,
		StRefPrecharge, StRefNop, StRefCmd, StRefNop1, StRefNop2, StRefNop3
	} seqState_e;

	typedef struct packed {
		logic [BankWidth-1:0] bank;                         // address bits 24 to 23
		logic [RowWidth-1:0]  row;                          // address bits 22 to 10
		logic [ColWidth-1:0]  column;                       // address bits 9 to 0
		logic                 isWrite;                      // set when WE_L was low at capture
		logic [DataWidth-1:0] writeData;                    // word taken from the CPU data bus
	} cpuRequest_t;

	typedef struct packed {
		sdramCmd_e            cmd;                          // command for the next rising edge
		logic [RowWidth-1:0]  addr;                         // row, column or mode word
		logic [BankWidth-1:0] bank;
		logic                 driveData;                    // FPGA owns DQ in this cycle
		logic                 latchRead;                    // capture DQ on the following falling edge
		logic                 dtack;                        // acknowledge the CPU, active high here
		logic                 cpuRun;                       // releases the CPU reset
	} sdramDrive_t;

endpackage

`default_nettype wire
